// ==== all.f ====
verilog/pager_pkg.sv
verilog/zbus_if.sv
verilog/pager_cfg_if.sv
verilog/pager_cfg_regs.sv
verilog/atm_window_pager.sv
verilog/dos_tracker.sv
verilog/memory_pager_top.sv
tb/pager_clk_gen.sv
tb/pager_tb.sv

// ==== Bender.yml ====
package:
  name: memory_pager

sources:
  - files:
      - verilog/pager_pkg.sv
      - verilog/zbus_if.sv
      - verilog/pager_cfg_if.sv
      - verilog/pager_cfg_regs.sv
      - verilog/atm_window_pager.sv
      - verilog/dos_tracker.sv
      - verilog/memory_pager_top.sv
  - target: test
    files:
      - tb/pager_clk_gen.sv
      - tb/pager_tb.sv

// ==== tb/pager_tb.sv ====
/* testbench for the memory pager: lfsr stimulus, register model of all ports,
   page selection model, compare tasks and the reset, port, override and dos checks */
`timescale 1ns/1ps
`default_nettype none

module pager_tb;

	localparam int STALL_LEN  = 3;
	localparam int RESET_WAIT = 40; // cycles until reset release
	localparam int DOS_WAIT   = 20;
	localparam int STALL_WAIT = 20;
	localparam int ROUNDS     = 40;

	logic             fclk, rst_n;
	logic [15:0]      za;
	logic [7:0]       zd;
	logic             mreq_n, m1_n, zpos, zneg, io_wr, in_nmi;
	pager_pkg::page_t page;
	logic             romnram, dos, zclk_stall, dos_turn_on;
	logic [7:0]       rd_data;

	// register model
	pager_pkg::page_t m_pg [4][2]; // per window and bank
	logic             m_rn [4][2]; // ramnrom
	logic             m_d7 [4][2]; // dos_7ffd
	logic             m_rom;       // 7ffd d4 picks the bank
	logic [5:0]       m_pent;
	logic             m_ram0, m_1m;
	pager_pkg::page_t m_rp, m_rpsh;
	logic [7:0]       m_memconf;
	logic             m_dos;

	logic [31:0] lfsr;

	pager_clk_gen #(.PERIOD(20), .RST_CYCLES(10)) u_clk (.fclk(fclk), .rst_n(rst_n));

	memory_pager_top #(.STALL_LEN(STALL_LEN)) dut (
		.fclk        (fclk),
		.rst_n       (rst_n),
		.za          (za),
		.zd          (zd),
		.mreq_n      (mreq_n),
		.m1_n        (m1_n),
		.zpos        (zpos),
		.zneg        (zneg),
		.io_wr       (io_wr),
		.in_nmi      (in_nmi),
		.page        (page),
		.romnram     (romnram),
		.dos         (dos),
		.zclk_stall  (zclk_stall),
		.dos_turn_on (dos_turn_on),
		.rd_data     (rd_data)
	);

	// galois lfsr with taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ 32'h8020_0003;
		else
			return s >> 1;
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsr_next(lfsr);
			v    = {v[30:0], lfsr[0]}; // one step per bit
		end
	endtask

	task automatic stop_run();
		$display("Something failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic timed_out(input string what);
		$display("timeout while waiting for %s", what);
		stop_run();
	endtask

	task automatic compare_page(input string name, input pager_pkg::page_t got,
		input pager_pkg::page_t exp);
		if (got !== exp)
		begin
			$display("CHECK FAILED t=%0t %s got=%h exp=%h", $time, name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("CHECK FAILED t=%0t %s got=%b exp=%b", $time, name, got, exp);
			stop_run();
		end
	endtask

	task automatic verify_readback(input string name, input logic [7:0] got,
		input logic [7:0] exp);
		if (got !== exp)
		begin
			$display("CHECK FAILED t=%0t %s got=%h exp=%h", $time, name, got, exp);
			stop_run();
		end
	endtask

	// drive point is 2 ns after the rising edge
	task automatic next_cycle();
		@(posedge fclk);
		#2;
	endtask

	task automatic idle_bus();
		za     = 16'h0000;
		io_wr  = 1'b0;
		mreq_n = 1'b1;
		m1_n   = 1'b1;
		zpos   = 1'b0; // phases held low keep the bus unsampled
		zneg   = 1'b0;
	endtask

	task automatic io_write(input logic [15:0] addr, input logic [7:0] data);
		za    = addr;
		zd    = data;
		io_wr = 1'b1;
		next_cycle(); // taken at this edge
		io_wr = 1'b0;
		za    = 16'h0000;
	endtask

	task automatic load_7ffd(input logic [7:0] data);
		io_write({pager_pkg::PORT_7FFD_HI, pager_pkg::PORT_FD}, data);
		m_pent = {data[7:5], data[2:0]};
		m_rom  = data[4];
	endtask

	task automatic set_eff7(input logic [7:0] data);
		io_write({pager_pkg::PORT_EFF7_HI, pager_pkg::PORT_F7}, data);
		m_1m   = ~data[2]; // low enables 1M
		m_ram0 = data[3];
	endtask

	task automatic xt_write(input logic [1:0] sel, input logic [7:0] data);
		io_write({6'b000000, sel, pager_pkg::PORT_AF}, data);
		case (sel)
			2'b00:   m_rp      = data;
			2'b01:   m_rpsh    = data;
			2'b10:   m_memconf = data;
			default: ;
		endcase
	endtask

	// za[13:12] kept at 00 so the high byte never reads as EF
	task automatic atm_write(input logic [1:0] w, input logic big, input logic [7:0] data);
		io_write({w, 2'b00, big, 3'b000, pager_pkg::PORT_F7}, data);
		if (big)
		begin
			m_pg[w][m_rom] = ~{2'b11, data[5:0]};
			m_rn[w][m_rom] = data[6];
			m_d7[w][m_rom] = data[7];
		end
		else
		begin
			m_pg[w][m_rom] = ~data;
			m_rn[w][m_rom] = 1'b1; // dos_7ffd left as it was
		end
	endtask

	// priority selection of one window
	task automatic model_select(input int w, output pager_pkg::page_t p, output logic r);
		logic b;
		b = m_rom;
		if (m_memconf[2])
		begin
			p = 8'hFF;
			r = 1'b1;
		end
		else if (m_memconf[0])
		begin
			p = (m_memconf[1] && m_dos) ? m_rpsh : m_rp;
			r = 1'b0;
		end
		else if (w == 0 && in_nmi)
		begin
			p = 8'hFF;
			r = 1'b0;
		end
		else if (w == 0 && m_ram0)
		begin
			p = 8'h00;
			r = 1'b0;
		end
		else
		begin
			r = ~m_rn[w][b];
			if (!m_d7[w][b])
				p = m_pg[w][b];
			else if (m_rn[w][b] && m_1m)
				p = {m_pg[w][b][7:6], m_pent};
			else if (m_rn[w][b])
				p = {m_pg[w][b][7:3], m_pent[2:0]};
			else
				p = {m_pg[w][b][7:1], m_dos}; // rom half picked by dos
		end
	endtask

	// one edge to register the page and then every window through za
	task automatic sweep_windows();
		logic [31:0]      r;
		pager_pkg::page_t exp_page;
		logic             exp_rom;
		for (int w = 0; w < 4; w++)
		begin
			next_cycle();
			take_bits(14, r);
			za = {2'(w), r[13:0]};
			#6;
			model_select(w, exp_page, exp_rom);
			compare_page($sformatf("page[w%0d]", w), page, exp_page);
			check_flag($sformatf("romnram[w%0d]", w), romnram, exp_rom);
			check_flag("dos", dos, m_dos);
			check_flag("zclk_stall", zclk_stall, 1'b0);
		end
		next_cycle();
		za = 16'h0000;
	endtask

	task automatic read_window(input logic [1:0] w);
		logic [7:0] flags;
		flags = {m_d7[w][1], m_d7[w][0], m_rn[w][1], m_rn[w][0], 4'b0000};
		za = {w, 4'b0000, 2'b00, pager_pkg::PORT_BE};
		#6;
		verify_readback($sformatf("rd_data page0 w%0d", w), rd_data, m_pg[w][0]);
		next_cycle();
		za = {w, 4'b0000, 2'b01, pager_pkg::PORT_BE};
		#6;
		verify_readback($sformatf("rd_data page1 w%0d", w), rd_data, m_pg[w][1]);
		next_cycle();
		za = {w, 4'b0000, 2'b10, pager_pkg::PORT_BE};
		#6;
		verify_readback($sformatf("rd_data flags w%0d", w), rd_data, flags);
		next_cycle();
		za = 16'h0000;
	endtask

	// m1 low on zpos and mreq high on zneg before mreq falls on zneg
	// returns inside the strobe cycle
	task automatic m1_fetch(input logic [15:0] addr);
		za     = addr;
		m1_n   = 1'b0;
		mreq_n = 1'b1;
		zpos   = 1'b1;
		zneg   = 1'b0;
		next_cycle();
		zpos   = 1'b0;
		zneg   = 1'b1;
		next_cycle();
		mreq_n = 1'b0; // falling edge seen against the sampled high
		#6;
	endtask

	task automatic wait_dos(input logic level);
		int n;
		n = 0;
		while (dos !== level)
		begin
			if (n == DOS_WAIT)
				timed_out("dos flag change");
			n++;
			next_cycle();
			#6;
		end
	endtask

	initial
	begin : main
		logic [31:0] r;
		int          n;
		int          stall_cycles;

		zd     = 8'h00;
		in_nmi = 1'b0;
		idle_bus();
		lfsr   = 32'h1a94_9695;

		for (int w = 0; w < 4; w++)
		begin
			for (int b = 0; b < 2; b++)
			begin
				m_pg[w][b] = 8'h00;
				m_rn[w][b] = 1'b0;
				m_d7[w][b] = 1'b0;
			end
		end
		m_rom     = 1'b0;
		m_pent    = 6'd0;
		m_ram0    = 1'b0;
		m_1m      = 1'b0;
		m_rp      = 8'h00;
		m_rpsh    = 8'h00;
		m_memconf = pager_pkg::MEMCONF_RESET;
		m_dos     = 1'b0;

		n = 0;
		while (rst_n !== 1'b1)
		begin
			if (n == RESET_WAIT)
				timed_out("reset release");
			n++;
			@(posedge fclk);
		end
		#2;

		// pager off after reset gives rom FF everywhere with registers clear
		sweep_windows();
		for (int w = 0; w < 4; w++)
			read_window(2'(w));
		za = {8'h03, pager_pkg::PORT_BE}; // za[9:8] 11 is memconf
		#6;
		verify_readback("rd_data memconf", rd_data, pager_pkg::MEMCONF_RESET);
		next_cycle();

		// xxF7 writes into random windows and banks and read back via xxBE
		for (int i = 0; i < ROUNDS; i++)
		begin
			take_bits(8, r);
			load_7ffd(r[7:0]); // d4 picks the bank
			take_bits(11, r);
			atm_write(r[1:0], r[2], r[10:3]);
			next_cycle();
			read_window(r[1:0]);
		end

		// 7FFD and EFF7 paging over random windows with the pager on
		xt_write(2'b10, 8'h00);
		for (int i = 0; i < ROUNDS; i++)
		begin
			take_bits(8, r);
			load_7ffd(r[7:0]);
			take_bits(8, r);
			set_eff7(r[7:0]);
			take_bits(11, r);
			atm_write(r[1:0], r[2], r[10:3]);
			sweep_windows();
		end

		// window 0 nmi and ram0_0
		set_eff7(8'h00);
		in_nmi = 1'b1;
		sweep_windows();
		in_nmi = 1'b0;
		set_eff7(8'h08);
		sweep_windows();
		set_eff7(8'h04);
		sweep_windows();

		// xt override where shadow without dos still gives rampage
		take_bits(16, r);
		xt_write(2'b00, r[7:0]);
		xt_write(2'b01, r[15:8]);
		xt_write(2'b10, 8'h01);
		sweep_windows();
		xt_write(2'b10, 8'h03);
		sweep_windows();
		xt_write(2'b10, 8'h00);

		// dos rom in bank 1 of window 0 and ram in window 2
		take_bits(8, r);
		load_7ffd({r[7:5], 1'b1, r[3:0]});
		set_eff7(8'h04); // 128k mode without ram0_0
		take_bits(14, r);
		atm_write(2'd0, 1'b1, {2'b10, r[5:0]});
		atm_write(2'd2, 1'b0, r[13:6]);
		sweep_windows();

		take_bits(8, r);
		m1_fetch({2'b00, pager_pkg::DOS_ENTRY_HI, r[7:0]});
		check_flag("dos_turn_on", dos_turn_on, 1'b1);
		check_flag("zclk_stall", zclk_stall, 1'b1);
		stall_cycles = 0;
		while (zclk_stall)
		begin
			stall_cycles++;
			if (stall_cycles > STALL_WAIT)
				timed_out("zclk_stall to drop");
			next_cycle();
			idle_bus();
			#6;
		end
		if (stall_cycles != 1 + STALL_LEN)
		begin
			$display("CHECK FAILED t=%0t zclk_stall cycles got=%0d exp=%0d", $time,
				stall_cycles, 1 + STALL_LEN);
			stop_run();
		end
		wait_dos(1'b1);
		m_dos = 1'b1;
		next_cycle();
		sweep_windows(); // rom bit 0 now follows dos

		// shadow page with dos set
		xt_write(2'b10, 8'h03);
		sweep_windows();
		xt_write(2'b10, 8'h01);
		sweep_windows();
		xt_write(2'b10, 8'h00);

		// fetch from the ram window leaves dos
		take_bits(8, r);
		m1_fetch({2'b10, 6'h01, r[7:0]});
		check_flag("dos_turn_on", dos_turn_on, 1'b0);
		next_cycle();
		idle_bus();
		#6;
		wait_dos(1'b0);
		m_dos = 1'b0;
		next_cycle();
		sweep_windows();

		$display("Everything OK");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb/pager_clk_gen.sv ====
/* testbench clock and power-on reset */
`timescale 1ns/1ps
`default_nettype none

module pager_clk_gen #(
	parameter int PERIOD     = 20, // ns
	parameter int RST_CYCLES = 10
) (
	output logic fclk,
	output logic rst_n
);

	initial
	begin
		fclk = 1'b0;
		forever #(PERIOD / 2) fclk = ~fclk;
	end

	initial
	begin
		rst_n = 1'b0;
		repeat (RST_CYCLES) @(posedge fclk);
		#2; // release away from the edge
		rst_n = 1'b1;
	end

endmodule

`default_nettype wire

// ==== verilog/memory_pager_top.sv ====
/* memory pager top: config block, four window pagers, DOS tracker
   and the page mux of the addressed window */
`timescale 1ns/1ps
`default_nettype none

module memory_pager_top #(
	parameter int STALL_LEN = 3
) (
	input  logic        fclk,
	input  logic        rst_n,
	input  logic [15:0] za,
	input  logic [7:0]  zd,
	input  logic        mreq_n,
	input  logic        m1_n,
	input  logic        zpos,
	input  logic        zneg,
	input  logic        io_wr,
	input  logic        in_nmi,
	output logic [7:0]  page,
	output logic        romnram,
	output logic        dos,
	output logic        zclk_stall,
	output logic        dos_turn_on,
	output logic [7:0]  rd_data
);

	zbus_if      zbus ();
	pager_cfg_if cfg ();

	pager_pkg::page_t win_page  [4];
	logic [3:0]       win_romnram;
	logic [3:0]       win_on, win_off, win_stall;
	pager_pkg::page_t win_page0 [4];
	pager_pkg::page_t win_page1 [4];
	logic [7:0]       win_flags [4];

	assign zbus.za     = za;
	assign zbus.zd     = zd;
	assign zbus.mreq_n = mreq_n;
	assign zbus.m1_n   = m1_n;
	assign zbus.zpos   = zpos;
	assign zbus.zneg   = zneg;
	assign zbus.io_wr  = io_wr;

	pager_cfg_regs u_cfg_regs (
		.fclk      (fclk),
		.rst_n     (rst_n),
		.zbus      (zbus),
		.cfg       (cfg),
		.win_page0 (win_page0),
		.win_page1 (win_page1),
		.win_flags (win_flags),
		.rd_data   (rd_data)
	);

	for (genvar i = 0; i < 4; i++)
	begin : g_win
		atm_window_pager #(
			.WIN_ADDR  (2'(i)),
			.STALL_LEN (STALL_LEN)
		) u_win (
			.fclk         (fclk),
			.rst_n        (rst_n),
			.zbus         (zbus),
			.cfg          (cfg),
			.dos          (dos),
			.in_nmi       (in_nmi),
			.page         (win_page[i]),
			.romnram      (win_romnram[i]),
			.dos_turn_on  (win_on[i]),
			.dos_turn_off (win_off[i]),
			.win_stall    (win_stall[i]),
			.rd_page0     (win_page0[i]),
			.rd_page1     (win_page1[i]),
			.rd_flags     (win_flags[i])
		);
	end

	dos_tracker u_dos (
		.fclk       (fclk),
		.rst_n      (rst_n),
		.turn_on    (win_on),
		.turn_off   (win_off),
		.win_stall  (win_stall),
		.dos        (dos),
		.zclk_stall (zclk_stall)
	);

	// page of the window the z80 is addressing now
	assign page        = win_page[za[15:14]];
	assign romnram     = win_romnram[za[15:14]];
	assign dos_turn_on = |win_on;

endmodule

`default_nettype wire

// ==== verilog/dos_tracker.sv ====
/* DOS flag with set over clear, merged z80 clock stall of all windows */
`timescale 1ns/1ps
`default_nettype none

module dos_tracker (
	input  logic       fclk,
	input  logic       rst_n,
	input  logic [3:0] turn_on,   // per-window entry strobes
	input  logic [3:0] turn_off,  // per-window exit strobes
	input  logic [3:0] win_stall,
	output logic       dos,
	output logic       zclk_stall
);

	logic dos_q;

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
			dos_q <= 1'b0;
		else if (|turn_on)
			dos_q <= 1'b1; // entry wins a tie
		else if (|turn_off)
			dos_q <= 1'b0;
	end

	assign dos        = dos_q;
	assign zclk_stall = |win_stall;

	// every entry must stall the z80 in its own cycle
	property p_stall_on_entry;
		@(posedge fclk) disable iff (!rst_n)
		(|turn_on) |-> zclk_stall;
	endproperty
	a_stall_on_entry: assert property (p_stall_on_entry)
		else $error("dos entry without clock stall");

endmodule

`default_nettype wire

// ==== verilog/atm_window_pager.sv ====
/* pager of one 16k window: xxF7 page banks, registered page select,
   DOS entry/exit strobes and z80 clock stall counter */
`timescale 1ns/1ps
`default_nettype none

module atm_window_pager #(
	parameter logic [1:0] WIN_ADDR  = 2'd0, // window number, za[15:14]
	parameter int         STALL_LEN = 3     // extra stall cycles after DOS entry
) (
	input  logic             fclk,
	input  logic             rst_n,
	zbus_if.sink             zbus,
	pager_cfg_if.dst         cfg,
	input  logic             dos,
	input  logic             in_nmi,
	output pager_pkg::page_t page,
	output logic             romnram,
	output logic             dos_turn_on,
	output logic             dos_turn_off,
	output logic             win_stall,
	output pager_pkg::page_t rd_page0,
	output pager_pkg::page_t rd_page1,
	output logic [7:0]       rd_flags
);

	localparam int CNT_W = (STALL_LEN < 1) ? 1 : $clog2(STALL_LEN + 1);

	pager_pkg::page_t pages [2]; // bank 0/1, picked by pent1m_rom
	logic [1:0]       ramnrom;   // 1 = ram
	logic [1:0]       dos_7ffd;  // 7ffd bits for ram, dos bit for rom

	logic       bank;
	logic       win_hit;
	logic       atm_wr;
	logic       m1_n_q, mreq_n_q;
	logic       fetch_stb;
	logic [CNT_W-1:0] stall_cnt;

	assign bank    = cfg.pent1m_rom;
	assign win_hit = zbus.za[15:14] == WIN_ADDR;
	assign atm_wr  = zbus.io_wr && win_hit && zbus.za[7:0] == pager_pkg::PORT_F7
		&& zbus.za[15:8] != pager_pkg::PORT_EFF7_HI; // EFF7 belongs to the config block

	// xxF7 writes into the bank currently picked by 7ffd d4
	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			pages[0] <= pager_pkg::PAGE_RESET;
			pages[1] <= pager_pkg::PAGE_RESET;
			ramnrom  <= 2'b00;
			dos_7ffd <= 2'b00;
		end
		else if (atm_wr)
		begin
			if (zbus.za[11])
			begin
				// 1M kind, x7f7 cousins are 4M
				pages[bank]    <= ~{2'b11, zbus.zd[5:0]};
				ramnrom[bank]  <= zbus.zd[6];
				dos_7ffd[bank] <= zbus.zd[7];
			end
			else
			begin
				pages[bank]   <= ~zbus.zd;
				ramnrom[bank] <= 1'b1; // always ram
				// dos_7ffd kept, so 7ffd paging can work anywhere in 4M
			end
		end
	end

	assign rd_page0 = pages[0];
	assign rd_page1 = pages[1];
	assign rd_flags = {dos_7ffd, ramnrom, 4'b0000};

	// page selection, one cycle behind the registers
	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			page    <= pager_pkg::PAGE_RESET;
			romnram <= 1'b0;
		end
		else if (cfg.pager_off)
		begin
			page    <= pager_pkg::PAGE_LAST; // service rom in every window
			romnram <= 1'b1;
		end
		else if (cfg.xt_override)
		begin
			page    <= (cfg.xt_shadow && dos) ? cfg.xt_rampagsh : cfg.xt_rampage;
			romnram <= 1'b0;
		end
		else if (WIN_ADDR == 2'd0 && in_nmi)
		begin
			page    <= pager_pkg::PAGE_LAST; // nmi handler lives in the last ram page
			romnram <= 1'b0;
		end
		else if (WIN_ADDR == 2'd0 && cfg.pent1m_ram0_0)
		begin
			page    <= pager_pkg::PAGE_RESET; // ram page 0
			romnram <= 1'b0;
		end
		else
		begin
			romnram <= ~ramnrom[bank];
			if (!dos_7ffd[bank])
				page <= pages[bank];
			else if (ramnrom[bank] && cfg.pent1m_1m_on)
				page <= {pages[bank][7:6], cfg.pent1m_page}; // whole 1M from 7ffd
			else if (ramnrom[bank])
				page <= {pages[bank][7:3], cfg.pent1m_page[2:0]}; // 128k mode
			else
				page <= {pages[bank][7:1], dos}; // rom pair, dos picks the half
		end
	end

	// m1 on the rising phase, mreq on the falling one
	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
			m1_n_q <= 1'b0;
		else if (zbus.zpos)
			m1_n_q <= zbus.m1_n;
	end

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
			mreq_n_q <= 1'b0;
		else if (zbus.zneg)
			mreq_n_q <= zbus.mreq_n;
	end

	// opcode fetch start in this window
	assign fetch_stb = zbus.zneg && win_hit && !m1_n_q && !zbus.mreq_n && mreq_n_q;

	assign dos_turn_on = fetch_stb && zbus.za[13:8] == pager_pkg::DOS_ENTRY_HI
		&& dos_7ffd[1] && !ramnrom[1] && cfg.pent1m_rom; // only from the dos rom bank
	assign dos_turn_off = fetch_stb && ramnrom[bank];

	// hold the z80 clock while the rom swaps to the dos half
	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
			stall_cnt <= '0;
		else if (dos_turn_on)
			stall_cnt <= CNT_W'(STALL_LEN);
		else if (stall_cnt != '0)
			stall_cnt <= stall_cnt - 1'b1;
	end

	assign win_stall = dos_turn_on || stall_cnt != '0;

	// a running stall only counts down, a new entry is the only way to reload
	property p_stall_no_restart;
		@(posedge fclk) disable iff (!rst_n)
		(stall_cnt != '0) && !dos_turn_on |=> stall_cnt < $past(stall_cnt);
	endproperty
	a_stall_no_restart: assert property (p_stall_no_restart)
		else $error("stall counter restarted without dos entry");

endmodule

`default_nettype wire

// ==== verilog/pager_cfg_regs.sv ====
/* config block: 7FFD, EFF7 and xxAF port registers, shared mapping controls,
   xxBE readback mux over the four windows */
`timescale 1ns/1ps
`default_nettype none

module pager_cfg_regs (
	input  logic             fclk,
	input  logic             rst_n,
	zbus_if.sink             zbus,
	pager_cfg_if.src         cfg,
	input  pager_pkg::page_t win_page0 [4],
	input  pager_pkg::page_t win_page1 [4],
	input  logic [7:0]       win_flags [4],
	output pager_pkg::page_t rd_data
);

	logic wr_7ffd, wr_eff7, wr_af, wr_atm;
	logic [7:0] lo_byte, hi_byte;

	logic                              pent1m_rom;
	logic [pager_pkg::PENT_PAGE_W-1:0] pent1m_page;
	logic                              pent1m_ram0_0;
	logic                              pent1m_1m_on;
	pager_pkg::page_t                  xt_rampage;
	pager_pkg::page_t                  xt_rampagsh;
	logic [7:0]                        memconf;

	logic [1:0] rd_win;

	assign lo_byte = zbus.za[7:0];
	assign hi_byte = zbus.za[15:8];

	assign wr_7ffd = zbus.io_wr && lo_byte == pager_pkg::PORT_FD
		&& hi_byte == pager_pkg::PORT_7FFD_HI;
	assign wr_eff7 = zbus.io_wr && lo_byte == pager_pkg::PORT_F7
		&& hi_byte == pager_pkg::PORT_EFF7_HI;
	assign wr_af   = zbus.io_wr && lo_byte == pager_pkg::PORT_AF;
	// ATM xxF7 writes as the windows see them
	assign wr_atm  = zbus.io_wr && lo_byte == pager_pkg::PORT_F7
		&& hi_byte != pager_pkg::PORT_EFF7_HI;

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			pent1m_rom    <= 1'b0;
			pent1m_page   <= pager_pkg::PENT_PAGE_RESET;
			pent1m_ram0_0 <= 1'b0;
			pent1m_1m_on  <= 1'b0;
			xt_rampage    <= pager_pkg::PAGE_RESET;
			xt_rampagsh   <= pager_pkg::PAGE_RESET;
			memconf       <= pager_pkg::MEMCONF_RESET;
		end
		else
		begin
			if (wr_7ffd)
			begin
				pent1m_page <= {zbus.zd[7:5], zbus.zd[2:0]}; // d3 is the screen bit, not ours
				pent1m_rom  <= zbus.zd[4];
			end
			if (wr_eff7)
			begin
				pent1m_1m_on  <= ~zbus.zd[2]; // active low in the port
				pent1m_ram0_0 <= zbus.zd[3];
			end
			if (wr_af)
			begin
				case (zbus.za[9:8])
					pager_pkg::AF_RAMPAGE:  xt_rampage  <= zbus.zd;
					pager_pkg::AF_RAMPAGSH: xt_rampagsh <= zbus.zd;
					pager_pkg::AF_MEMCONF:  memconf     <= zbus.zd;
					default: ; // 11 is not decoded
				endcase
			end
		end
	end

	assign cfg.pent1m_rom    = pent1m_rom;
	assign cfg.pent1m_page   = pent1m_page;
	assign cfg.pent1m_ram0_0 = pent1m_ram0_0;
	assign cfg.pent1m_1m_on  = pent1m_1m_on;
	assign cfg.xt_rampage    = xt_rampage;
	assign cfg.xt_rampagsh   = xt_rampagsh;
	assign cfg.xt_override   = memconf[pager_pkg::MC_XT_OVERRIDE];
	assign cfg.xt_shadow     = memconf[pager_pkg::MC_XT_SHADOW];
	assign cfg.pager_off     = memconf[pager_pkg::MC_PAGER_OFF];

	// xxBE readback, window from za[15:14], field from za[9:8]
	assign rd_win = zbus.za[15:14];

	always_comb
	begin
		rd_data = 8'hFF; // idle bus value off the port
		if (lo_byte == pager_pkg::PORT_BE)
		begin
			case (zbus.za[9:8])
				pager_pkg::RD_PAGE0:   rd_data = win_page0[rd_win];
				pager_pkg::RD_PAGE1:   rd_data = win_page1[rd_win];
				pager_pkg::RD_FLAGS:   rd_data = win_flags[rd_win];
				pager_pkg::RD_MEMCONF: rd_data = memconf;
				default:               rd_data = 8'hFF;
			endcase
		end
	end

	// at most one port register file is written per strobe, across regs and windows
	property p_one_port_decode;
		@(posedge fclk) disable iff (!rst_n)
		$onehot0({wr_7ffd, wr_eff7, wr_af, wr_atm});
	endproperty
	a_one_port_decode: assert property (p_one_port_decode)
		else $error("more than one port decode in a single io write");

endmodule

`default_nettype wire

// ==== verilog/pager_cfg_if.sv ====
/* shared mapping controls from the config block to every window pager */
`timescale 1ns/1ps
`default_nettype none

interface pager_cfg_if;

	logic                                pent1m_rom;    // 7ffd d4, picks page bank
	logic [pager_pkg::PENT_PAGE_W-1:0]   pent1m_page;   // 1M page from 7ffd
	logic                                pent1m_ram0_0; // ram page 0 in window 0
	logic                                pent1m_1m_on;  // 1M addressing of 7ffd
	pager_pkg::page_t                    xt_rampage;
	pager_pkg::page_t                    xt_rampagsh;   // shadow page, used with dos
	logic                                xt_override;
	logic                                xt_shadow;
	logic                                pager_off;     // service rom everywhere

	modport src (
		output pent1m_rom,
		output pent1m_page,
		output pent1m_ram0_0,
		output pent1m_1m_on,
		output xt_rampage,
		output xt_rampagsh,
		output xt_override,
		output xt_shadow,
		output pager_off
	);

	modport dst (
		input pent1m_rom,
		input pent1m_page,
		input pent1m_ram0_0,
		input pent1m_1m_on,
		input xt_rampage,
		input xt_rampagsh,
		input xt_override,
		input xt_shadow,
		input pager_off
	);

endinterface

`default_nettype wire

// ==== verilog/zbus_if.sv ====
/* sampled Z80 bus bundle for the config block and the window pagers */
`timescale 1ns/1ps
`default_nettype none

interface zbus_if;

	logic [15:0] za;     // z80 address
	logic [7:0]  zd;     // z80 data, port write payload
	logic        mreq_n; // memory request
	logic        m1_n;   // opcode fetch
	logic        zpos;   // z80 clock rising phase
	logic        zneg;   // z80 clock falling phase
	logic        io_wr;  // one-cycle io write strobe

	// every consumer only reads the bus
	modport sink (
		input za,
		input zd,
		input mreq_n,
		input m1_n,
		input zpos,
		input zneg,
		input io_wr
	);

endinterface

`default_nettype wire

// ==== verilog/pager_pkg.sv ====
/* shared constants for the ATM-style pager: port decode bytes, field widths,
   readback selectors and reset values */
`default_nettype none

package pager_pkg;

	typedef logic [7:0] page_t; // one 16k page of the 4M space

	// field widths
	localparam int WIN_NUM_W   = 2; // four 16k windows in the z80 space
	localparam int PENT_PAGE_W = 6; // 7ffd page bits, pentagon-1024

	// low address bytes of the ports
	localparam logic [7:0] PORT_F7 = 8'hF7; // ATM page ports, also low byte of EFF7
	localparam logic [7:0] PORT_AF = 8'hAF; // XT ram page and memconf ports
	localparam logic [7:0] PORT_BE = 8'hBE; // readback port
	localparam logic [7:0] PORT_FD = 8'hFD; // low byte of 7FFD

	// high bytes that finish the full decodes
	localparam logic [7:0] PORT_7FFD_HI = 8'h7F;
	localparam logic [7:0] PORT_EFF7_HI = 8'hEF;

	// za[9:8] register select on xxAF writes
	localparam logic [1:0] AF_RAMPAGE   = 2'b00;
	localparam logic [1:0] AF_RAMPAGSH  = 2'b01;
	localparam logic [1:0] AF_MEMCONF   = 2'b10;

	// za[9:8] field select on xxBE reads
	localparam logic [1:0] RD_PAGE0   = 2'b00;
	localparam logic [1:0] RD_PAGE1   = 2'b01;
	localparam logic [1:0] RD_FLAGS   = 2'b10;
	localparam logic [1:0] RD_MEMCONF = 2'b11; // extra, returns memconf as written

	// code block whose M1 fetch enters DOS (3Dxx)
	localparam logic [5:0] DOS_ENTRY_HI = 6'h3D;

	// page seen with the pager off, and in window 0 during nmi
	localparam page_t PAGE_LAST = 8'hFF;

	// memconf fields
	localparam int MC_XT_OVERRIDE = 0;
	localparam int MC_XT_SHADOW   = 1;
	localparam int MC_PAGER_OFF   = 2;

	// reset values
	localparam logic [7:0] MEMCONF_RESET = 8'h04; // pager off, no xt override
	localparam page_t      PAGE_RESET    = 8'h00;
	localparam logic [PENT_PAGE_W-1:0] PENT_PAGE_RESET = '0;

endpackage

`default_nettype wire
